//--- common/hub75_cfg.svh
// ######################################
// hub75 panel configuration
// geometry, bit depth and output-enable timing
// ######################################
`ifndef HUB75_CFG_SVH
`define HUB75_CFG_SVH

// columns shifted out per line
`define HUB75_PANEL_WIDTH 64

// rows per subpanel, top and bottom share the row address
`define HUB75_SUBPANEL_ROWS 16

// bit planes per colour channel
`define HUB75_BRIGHTNESS_BITS 4

// clk_in cycles of output enable per unit of mask weight
`define HUB75_OE_UNIT 80

// remaining on-time at which the next line may start shifting
// one full line plus the strobe and latch cycles
`define HUB75_OVERLAP_CYCLES (`HUB75_PANEL_WIDTH + 2)

`endif

//--- common/hub75_pkg.sv
// ######################################
// hub75 shared types
// addresses, brightness masks, pixels and host writes
// ######################################
`include "hub75_cfg.svh"

package hub75_pkg;

    // column index, 0 .. 63
    typedef logic [$clog2(`HUB75_PANEL_WIDTH)-1:0] col_addr_t;

    // column count, one bit wider so it holds the full width
    typedef logic [$clog2(`HUB75_PANEL_WIDTH):0] col_addr_count_t;

    // row within one subpanel
    typedef logic [$clog2(`HUB75_SUBPANEL_ROWS)-1:0] row_subpanel_addr_t;

    // one-hot bit-plane select, msb is the heaviest plane
    typedef logic [`HUB75_BRIGHTNESS_BITS-1:0] brightness_level_t;

    // output-enable countdown, holds oe unit times the top weight
    typedef logic [9:0] oe_count_t;

    // single colour channel
    typedef logic [`HUB75_BRIGHTNESS_BITS-1:0] channel_t;

    typedef struct packed {
        channel_t r;
        channel_t g;
        channel_t b;
    } rgb_t;

    // row msb selects the bottom subpanel
    typedef struct packed {
        logic [$clog2(`HUB75_SUBPANEL_ROWS):0] row;
        col_addr_t column;
    } pixel_addr_t;

    typedef struct packed {
        pixel_addr_t addr;
        rgb_t colour;
    } pixel_write_t;

    // data pins of the panel, 0 is top half, 1 is bottom half
    typedef struct packed {
        logic r0;
        logic g0;
        logic b0;
        logic r1;
        logic g1;
        logic b1;
    } panel_bits_t;

endpackage

//--- source/timeout.sv
// ######################################
// loadable down-counter
// counts a loaded value to zero, flags while busy
// ######################################
module timeout #(
    parameter type count_t = logic [7:0]
) (
    input  logic   clk_in,
    input  logic   reset,
    input  logic   start,
    input  count_t value,
    output count_t counter,
    output logic   running
);

    // running is registered alongside the count
    // so it is valid in the same cycle as the loaded value
    always_ff @(posedge clk_in) begin
        if (reset) begin
            counter <= '0;
            running <= 1'b0;
        end else if (start) begin
            counter <= value;
            running <= (value != '0);
        end else if (counter != '0) begin
            counter <= counter - 1'b1;
            // drops together with the last decrement
            running <= (counter != count_t'(1));
        end
    end

    // flag and count must agree every cycle
    running_has_count: assert property (
        @(posedge clk_in) disable iff (reset)
        running |-> (counter != '0)
    );

endmodule

//--- matrix_scan/brightness_timeout.sv
// ######################################
// weighted output-enable timer
// lights a latched line for the plane weight
// ######################################
`include "hub75_cfg.svh"

module brightness_timeout
    import hub75_pkg::*;
(
    input  logic              clk_in,
    input  logic              reset,
    input  logic              row_latch,
    input  brightness_level_t brightness_mask_active,
    output logic              output_enable,
    output logic              exceeded_overlap_time
);

    // remaining on-time after the current cycle
    oe_count_t oe_count;
    // full on-time for the active plane
    oe_count_t on_time;
    // one cycle after the latch, active mask is valid here
    logic latch_seen;

    // mask is one-hot, so its value is its weight
    assign on_time = oe_count_t'(`HUB75_OE_UNIT * brightness_mask_active);

    always_ff @(posedge clk_in) begin
        if (reset) begin
            latch_seen <= 1'b0;
            oe_count   <= '0;
        end else begin
            latch_seen <= row_latch;
            if (latch_seen) begin
                // first lit cycle is the latch_seen cycle itself
                oe_count <= on_time - 1'b1;
            end else if (oe_count != '0) begin
                oe_count <= oe_count - 1'b1;
            end
        end
    end

    // high from the cycle after row_latch for on_time cycles
    assign output_enable = latch_seen || (oe_count != '0);

    // tail of the on-time, long enough to shift the next line
    assign exceeded_overlap_time = (oe_count != '0) &&
                                   (oe_count <= oe_count_t'(`HUB75_OVERLAP_CYCLES));

    // the sequencer only ever hands over a single plane
    mask_onehot: assert property (
        @(posedge clk_in) disable iff (reset)
        $onehot0(brightness_mask_active)
    );

endmodule

//--- matrix_scan/matrix_scan.sv
// ######################################
// matrix scan sequencer
// shifts, latches and lights one line per bit plane
// ######################################
`include "hub75_cfg.svh"

module matrix_scan
    import hub75_pkg::*;
(
    input  logic               clk_in,
    input  logic               reset,
    output col_addr_t          column_address,
    output row_subpanel_addr_t row_address,
    output row_subpanel_addr_t row_address_active,
    output brightness_level_t  brightness_mask,
    output logic               pixel_load,
    output logic               pixel_strobe,
    output logic               row_latch,
    output logic               output_enable
);

    // heaviest plane, start of every row
    localparam brightness_level_t mask_top =
        brightness_level_t'(1) << (`HUB75_BRIGHTNESS_BITS - 1);

    // previous two samples of state_advance
    logic [1:0] scan_state;
    logic state_advance;
    logic line_start;

    // pixel_load delayed twice, for the latch pulse
    logic [1:0] latch_state;

    logic exceeded_overlap;
    brightness_level_t brightness_mask_active;

    // next line may shift while the last one is dark or nearly done
    assign state_advance = !output_enable || exceeded_overlap;
    assign line_start = (scan_state == 2'b01);

    always_ff @(posedge clk_in) begin
        if (reset) begin
            scan_state <= 2'b00;
        end else begin
            scan_state <= {scan_state[0], state_advance};
        end
    end

    // 64 load cycles per line
    timeout #(.count_t(col_addr_count_t)) u_load_timeout (
        .clk_in (clk_in),
        .reset  (reset),
        .start  (line_start),
        .value  (col_addr_count_t'(`HUB75_PANEL_WIDTH)),
        .counter(),
        .running(pixel_load)
    );

    // column 63 down to 0, in step with pixel_load
    timeout #(.count_t(col_addr_t)) u_column_timeout (
        .clk_in (clk_in),
        .reset  (reset),
        .start  (line_start),
        .value  (col_addr_t'(`HUB75_PANEL_WIDTH - 1)),
        .counter(column_address),
        .running()
    );

    // pulse two cycles after the last load
    assign row_latch = (latch_state == 2'b10);

    always_ff @(posedge clk_in) begin
        if (reset) begin
            pixel_strobe           <= 1'b0;
            latch_state            <= 2'b00;
            brightness_mask        <= mask_top;
            brightness_mask_active <= '0;
            row_address            <= '0;
            row_address_active     <= '0;
        end else begin
            // store data arrives one cycle after its address
            pixel_strobe <= pixel_load;
            latch_state  <= {latch_state[0], pixel_load};
            if (row_latch) begin
                // shifted line becomes the lit line
                brightness_mask_active <= brightness_mask;
                row_address_active     <= row_address;
                if (brightness_mask == brightness_level_t'(1)) begin
                    // last plane done, next row, wraps at 16
                    brightness_mask <= mask_top;
                    row_address     <= row_address + 1'b1;
                end else begin
                    brightness_mask <= brightness_mask >> 1;
                end
            end
        end
    end

    brightness_timeout u_brightness (
        .clk_in                (clk_in),
        .reset                 (reset),
        .row_latch             (row_latch),
        .brightness_mask_active(brightness_mask_active),
        .output_enable         (output_enable),
        .exceeded_overlap_time (exceeded_overlap)
    );

    // next line never starts before the latch of the current one
    latch_outside_load: assert property (
        @(posedge clk_in) disable iff (reset)
        row_latch |-> !pixel_load
    );

endmodule

//--- source/pixel_store.sv
// ######################################
// pixel memory
// four-phase host writes, bit-plane panel reads
// ######################################
module pixel_store
    import hub75_pkg::*;
(
    input  logic               clk_in,
    input  logic               reset,
    input  logic               host_req,
    input  pixel_write_t       host_wr,
    output logic               host_ack,
    input  col_addr_t          column_address,
    input  row_subpanel_addr_t row_address,
    input  brightness_level_t  brightness_mask,
    output panel_bits_t        panel_bits
);

    // both subpanels, indexed by {row, column}
    rgb_t mem [2**$bits(pixel_addr_t)];

    logic write_en;
    pixel_addr_t top_addr;
    pixel_addr_t bottom_addr;
    rgb_t top_px;
    rgb_t bottom_px;

    // new request seen, ack not yet given
    assign write_en = host_req && !host_ack;

    always_ff @(posedge clk_in) begin
        if (write_en) begin
            mem[host_wr.addr] <= host_wr.colour;
        end
    end

    // four-phase slave, ack follows req by one cycle both ways
    always_ff @(posedge clk_in) begin
        if (reset) begin
            host_ack <= 1'b0;
        end else if (write_en) begin
            host_ack <= 1'b1;
        end else if (!host_req) begin
            host_ack <= 1'b0;
        end
    end

    // bottom half is row + 16, the row msb
    assign top_addr    = '{row: {1'b0, row_address}, column: column_address};
    assign bottom_addr = '{row: {1'b1, row_address}, column: column_address};
    assign top_px      = mem[top_addr];
    assign bottom_px   = mem[bottom_addr];

    // pick the masked plane of each channel
    always_ff @(posedge clk_in) begin
        panel_bits.r0 <= |(top_px.r & brightness_mask);
        panel_bits.g0 <= |(top_px.g & brightness_mask);
        panel_bits.b0 <= |(top_px.b & brightness_mask);
        panel_bits.r1 <= |(bottom_px.r & brightness_mask);
        panel_bits.g1 <= |(bottom_px.g & brightness_mask);
        panel_bits.b1 <= |(bottom_px.b & brightness_mask);
    end

    // ack only ever answers a request seen the cycle before
    ack_needs_req: assert property (
        @(posedge clk_in) disable iff (reset)
        $rose(host_ack) |-> $past(host_req)
    );

endmodule

//--- source/hub75_top.sv
// ######################################
// hub75 driver top level
// pixel store and scan engine to panel pins
// ######################################
module hub75_top
    import hub75_pkg::*;
(
    input  logic               clk_in,
    input  logic               reset,
    input  logic               host_req,
    input  pixel_write_t       host_wr,
    output logic               host_ack,
    output panel_bits_t        panel_bits,
    output logic               pixel_strobe,
    output logic               row_latch,
    output logic               output_enable,
    output row_subpanel_addr_t row_address_active
);

    // read address from the sequencer into the store
    col_addr_t column_address;
    row_subpanel_addr_t row_address;
    brightness_level_t brightness_mask;

    pixel_store u_store (
        .clk_in         (clk_in),
        .reset          (reset),
        .host_req       (host_req),
        .host_wr        (host_wr),
        .host_ack       (host_ack),
        .column_address (column_address),
        .row_address    (row_address),
        .brightness_mask(brightness_mask),
        .panel_bits     (panel_bits)
    );

    // pixel_load stays internal, pins see the aligned strobe
    matrix_scan u_scan (
        .clk_in            (clk_in),
        .reset             (reset),
        .column_address    (column_address),
        .row_address       (row_address),
        .row_address_active(row_address_active),
        .brightness_mask   (brightness_mask),
        .pixel_load        (),
        .pixel_strobe      (pixel_strobe),
        .row_latch         (row_latch),
        .output_enable     (output_enable)
    );

endmodule

//--- verif/hub75_tb.sv
// ######################################
// hub75 scan engine testbench
// host fill, reference model, concurrent checks
// ######################################
`include "hub75_cfg.svh"

module hub75_tb
    import hub75_pkg::*;
;

    // cycles allowed for one ack edge
    localparam int ACK_TIMEOUT = 16;
    // lines checked once the memory is full, twelve rows
    localparam int CHECK_LINES = 12 * `HUB75_BRIGHTNESS_BITS;
    // one row is about 15 x 80 cycles lit, plus latch gaps
    localparam int SCAN_TIMEOUT = 20000;
    localparam brightness_level_t MASK_TOP =
        brightness_level_t'(1) << (`HUB75_BRIGHTNESS_BITS - 1);

    logic clk_in;
    logic reset;
    logic host_req;
    pixel_write_t host_wr;
    logic host_ack;
    panel_bits_t panel_bits;
    logic pixel_strobe;
    logic row_latch;
    logic output_enable;
    row_subpanel_addr_t row_address_active;

    // reference model state
    rgb_t ref_mem [2**$bits(pixel_addr_t)];
    row_subpanel_addr_t model_row;
    brightness_level_t model_mask;
    row_subpanel_addr_t lit_row;
    brightness_level_t lit_mask;
    int strobe_count;
    int oe_len;
    int latch_count;
    col_addr_t exp_col;
    rgb_t top_px;
    rgb_t bottom_px;
    panel_bits_t expected_bits;
    logic [3:0] idle_outputs;

    logic checking;
    logic timed_out;
    int error_count;
    logic [31:0] lfsr_state;

    hub75_top dut (
        .clk_in            (clk_in),
        .reset             (reset),
        .host_req          (host_req),
        .host_wr           (host_wr),
        .host_ack          (host_ack),
        .panel_bits        (panel_bits),
        .pixel_strobe      (pixel_strobe),
        .row_latch         (row_latch),
        .output_enable     (output_enable),
        .row_address_active(row_address_active)
    );

    always #10 clk_in = ~clk_in;

    // line model, mask walks 8 4 2 1 then the row steps
    always @(posedge clk_in) begin
        if (reset) begin
            model_row    <= '0;
            model_mask   <= MASK_TOP;
            lit_row      <= '0;
            lit_mask     <= '0;
            strobe_count <= 0;
            oe_len       <= 0;
            latch_count  <= 0;
        end else begin
            if (pixel_strobe) begin
                strobe_count <= strobe_count + 1;
            end
            if (row_latch) begin
                strobe_count <= 0;
                latch_count  <= latch_count + 1;
                lit_row      <= model_row;
                lit_mask     <= model_mask;
                if (model_mask == brightness_level_t'(1)) begin
                    model_mask <= MASK_TOP;
                    model_row  <= model_row + 1'b1;
                end else begin
                    model_mask <= model_mask >> 1;
                end
            end
            // length of the current lit stretch
            oe_len <= output_enable ? oe_len + 1 : 0;
        end
    end

    // columns leave the panel 63 first, top half then row + 16
    always_comb begin
        exp_col = col_addr_t'(`HUB75_PANEL_WIDTH - 1 - strobe_count);
        top_px = ref_mem[{1'b0, model_row, exp_col}];
        bottom_px = ref_mem[{1'b1, model_row, exp_col}];
        expected_bits.r0 = (top_px.r & model_mask) != '0;
        expected_bits.g0 = (top_px.g & model_mask) != '0;
        expected_bits.b0 = (top_px.b & model_mask) != '0;
        expected_bits.r1 = (bottom_px.r & model_mask) != '0;
        expected_bits.g1 = (bottom_px.g & model_mask) != '0;
        expected_bits.b1 = (bottom_px.b & model_mask) != '0;
    end

    assign idle_outputs = {output_enable, row_latch, pixel_strobe, host_ack};

    task automatic report_mismatch(input string name, input int expected, input int actual);
        error_count++;
        $display("[FAIL] %0t %s expected %0h got %0h", $time, name, expected, actual);
    endtask

    task automatic report_violation(input string what);
        error_count++;
        $display("error at %0t: %s", $time, what);
    endtask

    idle_after_reset: assert property (
        @(posedge clk_in) reset |=> (idle_outputs == '0)
    ) else report_mismatch("output_enable,row_latch,pixel_strobe,host_ack", 0,
                           $sampled(idle_outputs));

    ack_rise_needs_req: assert property (
        @(posedge clk_in) disable iff (reset)
        $rose(host_ack) |-> host_req
    ) else report_violation("host_ack rose while host_req was low");

    ack_fall_after_req: assert property (
        @(posedge clk_in) disable iff (reset)
        $fell(host_ack) |-> !$past(host_req)
    ) else report_violation("host_ack fell before host_req was dropped");

    strobes_per_line: assert property (
        @(posedge clk_in) disable iff (reset)
        row_latch |-> (strobe_count == `HUB75_PANEL_WIDTH)
    ) else report_mismatch("pixel_strobe count", `HUB75_PANEL_WIDTH,
                           $sampled(strobe_count));

    panel_bits_match: assert property (
        @(posedge clk_in) disable iff (reset)
        (checking && pixel_strobe) |-> (panel_bits == expected_bits)
    ) else report_mismatch("panel_bits", $sampled(expected_bits), $sampled(panel_bits));

    active_row_match: assert property (
        @(posedge clk_in) disable iff (reset)
        row_latch |=> (row_address_active == lit_row)
    ) else report_mismatch("row_address_active", $sampled(lit_row),
                           $sampled(row_address_active));

    oe_follows_latch: assert property (
        @(posedge clk_in) disable iff (reset)
        row_latch |=> output_enable
    ) else report_mismatch("output_enable", 1, $sampled(output_enable));

    // on-time is the oe unit times the weight of the lit plane
    oe_duration: assert property (
        @(posedge clk_in) disable iff (reset)
        $fell(output_enable) |-> (oe_len == `HUB75_OE_UNIT * int'(lit_mask))
    ) else report_mismatch("output_enable length", `HUB75_OE_UNIT * int'($sampled(lit_mask)),
                           $sampled(oe_len));

    dark_at_latch: assert property (
        @(posedge clk_in) disable iff (reset)
        row_latch |-> !output_enable
    ) else report_mismatch("output_enable at row_latch", 0, $sampled(output_enable));

    // fibonacci lfsr, taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        logic feedback;
        feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
        return {state[30:0], feedback};
    endfunction

    task automatic random_colour(output rgb_t colour);
        logic [$bits(rgb_t)-1:0] bits;
        for (int i = 0; i < $bits(rgb_t); i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            bits[i] = lfsr_state[0];
        end
        colour = bits;
    endtask

    // sampled at the falling edge, clear of the update edge
    task automatic wait_for_ack(input logic level);
        int cycles;
        cycles = 0;
        do begin
            @(negedge clk_in);
            cycles++;
        end while (host_ack !== level && cycles < ACK_TIMEOUT);
        if (host_ack !== level) begin
            timed_out = 1'b1;
            $display("timeout: host_ack did not go %0b within %0d cycles at %0t",
                     level, ACK_TIMEOUT, $time);
        end
    endtask

    // one four-phase write
    task automatic write_pixel(input pixel_write_t wr);
        @(posedge clk_in);
        host_wr  <= wr;
        host_req <= 1'b1;
        wait_for_ack(1'b1);
        if (!timed_out) begin
            @(posedge clk_in);
            host_req <= 1'b0;
            wait_for_ack(1'b0);
        end
    endtask

    task automatic fill_memory();
        pixel_write_t wr;
        for (int addr = 0; addr < 2**$bits(pixel_addr_t) && !timed_out; addr++) begin
            wr.addr = pixel_addr_t'(addr);
            random_colour(wr.colour);
            ref_mem[addr] = wr.colour;
            write_pixel(wr);
        end
    endtask

    // lets the scan run with the panel_bits check live
    task automatic run_scan_checks();
        int start_latches;
        int cycles;
        @(posedge clk_in);
        checking <= 1'b1;
        @(negedge clk_in);
        start_latches = latch_count;
        cycles = 0;
        while (latch_count < start_latches + CHECK_LINES && cycles < SCAN_TIMEOUT) begin
            @(negedge clk_in);
            cycles++;
        end
        if (latch_count < start_latches + CHECK_LINES) begin
            timed_out = 1'b1;
            $display("timeout: only %0d of %0d lines latched within %0d cycles",
                     latch_count - start_latches, CHECK_LINES, SCAN_TIMEOUT);
        end
    endtask

    initial begin
        clk_in = 1'b0;
        reset = 1'b1;
        host_req = 1'b0;
        host_wr = '0;
        checking = 1'b0;
        timed_out = 1'b0;
        error_count = 0;
        lfsr_state = 32'ha37a_f632;
        repeat (3) @(posedge clk_in);
        reset <= 1'b0;
        // scan keeps running while the host fills the store
        fill_memory();
        if (!timed_out) begin
            run_scan_checks();
        end
        $display("errors: %0d, timeouts: %0d", error_count, timed_out);
        if (error_count == 0 && !timed_out) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

//--- hub75.f
+incdir+common
common/hub75_pkg.sv
source/timeout.sv
matrix_scan/brightness_timeout.sv
matrix_scan/matrix_scan.sv
source/pixel_store.sv
source/hub75_top.sv
verif/hub75_tb.sv

//--- Bender.yml
package:
  name: hub75

sources:
  - include_dirs:
      - common
    files:
      - common/hub75_pkg.sv
      - source/timeout.sv
      - matrix_scan/brightness_timeout.sv
      - matrix_scan/matrix_scan.sv
      - source/pixel_store.sv
      - source/hub75_top.sv
  - target: simulation
    include_dirs:
      - common
    files:
      - verif/hub75_tb.sv
